/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_proto_top
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* baud_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module baud_timer #(
	parameter int BAUD_DIV = 16
) (
	input  wire logic clk_i,
	input  wire logic arst_n_i,
	input  wire logic restart_i,
	input  wire logic half_i,
	input  wire logic enable_i,
	output logic      tick_o
);

	// Room for a full period count
	localparam int CW = $clog2(BAUD_DIV + 1);

	// Reload values, tick fires when the count reaches zero
	localparam logic [CW-1:0] FULL_LOAD = CW'(BAUD_DIV - 1);
	localparam logic [CW-1:0] HALF_LOAD = CW'(BAUD_DIV / 2 - 1);

	logic [CW-1:0] cnt_q;

	// One cycle pulse per bit period
	assign tick_o = enable_i && (cnt_q == '0);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= FULL_LOAD;
		end else if (restart_i) begin
			// Half period lands the first tick mid start bit
			cnt_q <= half_i ? HALF_LOAD : FULL_LOAD;
		end else if (enable_i) begin
			if (cnt_q == '0) begin
				cnt_q <= FULL_LOAD;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* datamem_dp.sv */
`timescale 1ns/1ns
`default_nettype none

module datamem_dp
	import mcont_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  wire logic              clk_i,
	input  wire mem_port_t         a_req_i,
	output logic      [DATA_W-1:0] a_rdata_o,
	input  wire mem_port_t         b_req_i,
	output logic      [DATA_W-1:0] b_rdata_o
);

	// Index bits actually decoded
	localparam int AW = $clog2(MEM_WORDS);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic [AW-1:0] a_idx;
	logic [AW-1:0] b_idx;

	// Upper address bits ignored, memory wraps
	assign a_idx = a_req_i.addr[AW-1:0];
	assign b_idx = b_req_i.addr[AW-1:0];

	// Byte lane writes, port B first
	// Port A last, so it overrides on a shared word
	always_ff @(posedge clk_i) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (b_req_i.we[lane]) begin
				mem[b_idx][lane*8 +: 8] <= b_req_i.wdata[lane*8 +: 8];
			end
			if (a_req_i.we[lane]) begin
				mem[a_idx][lane*8 +: 8] <= a_req_i.wdata[lane*8 +: 8];
			end
		end
	end

	// Registered reads, old data on a same-cycle write
	always_ff @(posedge clk_i) begin
		a_rdata_o <= mem[a_idx];
		b_rdata_o <= mem[b_idx];
	end

endmodule

`default_nettype wire

/* mcont_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module mcont_fsm
	import mcont_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  wire logic              clk_i,
	input  wire logic              arst_n_i,
	output mem_port_t              mem_req_o,
	input  wire logic [DATA_W-1:0] mem_rdata_i,
	output logic                   tx_start_o,
	output byte_t                  tx_data_o,
	input  wire logic              tx_busy_i,
	input  wire logic              rx_valid_i,
	input  wire byte_t             rx_data_i,
	input  wire logic              rx_err_i
);

	// Data word addresses wrap inside the memory depth
	localparam logic [ADDR_W-1:0] ADDR_MASK = ADDR_W'(MEM_WORDS - 1);

	typedef enum logic [3:0] {
		IDLE_RD,
		IDLE_CHK,
		ACK,
		FETCH,
		FETCH_WAIT,
		SEND,
		SEND_WAIT,
		RECV,
		STATUS
	} state_t;

	state_t            state_q;
	mbox_cmd_t         cmd_q;
	logic [DATA_W-1:0] word_q;
	byte_t             count_q;
	logic [1:0]        lane_q;
	// Sticky over the whole job
	logic              err_q;

	mbox_u             rd_mbox;
	mbox_u             wr_mbox;
	logic [ADDR_W-1:0] data_addr;
	logic              job_end;
	logic              rx_take;

	// Read word seen as a command
	assign rd_mbox = mem_rdata_i;

	// Current data word at base plus count/4
	assign data_addr = (cmd_q.base + ADDR_W'(count_q[7:2])) & ADDR_MASK;
	assign job_end   = (count_q == cmd_q.len);
	assign rx_take   = (state_q == RECV) && rx_valid_i && !job_end;

	// Byte handoff to the transmitter
	assign tx_start_o = (state_q == SEND) && !tx_busy_i;
	assign tx_data_o  = word_q[{lane_q, 3'b000} +: 8];

	// Status view with busy on ack and done on the final write
	always_comb begin
		wr_mbox            = '0;
		wr_mbox.stat.busy  = (state_q == ACK);
		wr_mbox.stat.done  = (state_q == STATUS);
		wr_mbox.stat.err   = (state_q == STATUS) && err_q;
		wr_mbox.stat.count = count_q;
	end

	// Port B request
	always_comb begin
		mem_req_o.addr  = MBOX_ADDR;
		mem_req_o.wdata = wr_mbox;
		mem_req_o.we    = '0;
		case (state_q)
			ACK, STATUS: begin
				mem_req_o.we = 4'hF;
			end
			FETCH: begin
				mem_req_o.addr = data_addr;
			end
			RECV: begin
				// Byte copied to every lane with only its own lane enabled
				mem_req_o.addr  = data_addr;
				mem_req_o.wdata = {4{rx_data_i}};
				mem_req_o.we    = rx_take ? (4'b0001 << lane_q) : 4'b0000;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE_RD;
			cmd_q   <= '0;
			count_q <= '0;
			lane_q  <= '0;
			err_q   <= 1'b0;
		end else begin
			case (state_q)
				// Mailbox address out and data back next cycle
				IDLE_RD: state_q <= IDLE_CHK;
				IDLE_CHK: begin
					if (rd_mbox.cmd.go) begin
						cmd_q   <= rd_mbox.cmd;
						count_q <= '0;
						lane_q  <= '0;
						err_q   <= 1'b0;
						state_q <= ACK;
					end else begin
						state_q <= IDLE_RD;
					end
				end
				ACK: begin
					// Unknown op or empty job goes straight to status
					if (cmd_q.len == '0) begin
						state_q <= STATUS;
					end else if (cmd_q.op == OP_TX) begin
						state_q <= FETCH;
					end else if (cmd_q.op == OP_RX) begin
						state_q <= RECV;
					end else begin
						state_q <= STATUS;
					end
				end
				FETCH: state_q <= FETCH_WAIT;
				FETCH_WAIT: state_q <= SEND;
				SEND: begin
					if (!tx_busy_i) begin
						count_q <= count_q + 1'b1;
						lane_q  <= lane_q + 1'b1;
						state_q <= SEND_WAIT;
					end
				end
				SEND_WAIT: begin
					// Busy already up here until the stop bit ends
					if (!tx_busy_i) begin
						if (job_end) begin
							state_q <= STATUS;
						end else if (lane_q == 2'd0) begin
							state_q <= FETCH;
						end else begin
							state_q <= SEND;
						end
					end
				end
				RECV: begin
					if (job_end) begin
						state_q <= STATUS;
					end else if (rx_take) begin
						count_q <= count_q + 1'b1;
						lane_q  <= lane_q + 1'b1;
						err_q   <= err_q | rx_err_i;
					end
				end
				STATUS: state_q <= IDLE_RD;
				default: state_q <= IDLE_RD;
			endcase
		end
	end

	// Word being sent
	always_ff @(posedge clk_i) begin
		if (state_q == FETCH_WAIT) begin
			word_q <= mem_rdata_i;
		end
	end

endmodule

`default_nettype wire

/* mcont_pkg.sv */
`default_nettype none

package mcont_pkg;

	// Word address width of the shared data memory
	localparam int ADDR_W = 11;
	// Word width
	localparam int DATA_W = 32;

	// Mailbox word location
	localparam logic [ADDR_W-1:0] MBOX_ADDR = '0;

	// Job operation codes
	localparam logic [1:0] OP_TX = 2'd1;
	localparam logic [1:0] OP_RX = 2'd2;

	// One serial byte
	typedef logic [7:0] byte_t;

	// One word request toward a memory port
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		// Byte lane enables, lane 0 is bits 7:0
		logic [3:0]        we;
	} mem_port_t;

	// Mailbox as written by the processor
	typedef struct packed {
		logic [9:0]        rsvd;
		// First data word address
		logic [ADDR_W-1:0] base;
		// Job length in bytes
		byte_t             len;
		logic [1:0]        op;
		// Bit 0, shared with busy
		logic              go;
	} mbox_cmd_t;

	// Mailbox as written back by the controller
	typedef struct packed {
		logic [20:0] rsvd;
		// Bytes moved so far
		byte_t       count;
		// Framing error seen on receive
		logic        err;
		logic        done;
		// Bit 0, overlays go
		logic        busy;
	} mbox_stat_t;

	// Same mailbox word, command view or status view
	typedef union packed {
		mbox_cmd_t  cmd;
		mbox_stat_t stat;
	} mbox_u;

endpackage

`default_nettype wire

/* proto_top.sv */
`timescale 1ns/1ns
`default_nettype none

module proto_top
	import mcont_pkg::*;
#(
	parameter int BAUD_DIV  = 16,
	parameter int MEM_WORDS = 256
) (
	input  wire logic              clk_i,
	input  wire logic              arst_n_i,
	// Processor side word port
	input  wire logic [ADDR_W-1:0] core_addr_i,
	input  wire logic [DATA_W-1:0] core_wdata_i,
	input  wire logic [3:0]        core_we_i,
	output logic      [DATA_W-1:0] core_rdata_o,
	// Serial pins
	input  wire logic              uart_rxd_i,
	output logic                   uart_txd_o
);

	mem_port_t         core_req;
	mem_port_t         fsm_req;
	logic [DATA_W-1:0] fsm_rdata;

	logic  tx_start;
	byte_t tx_data;
	logic  tx_busy;
	logic  rx_valid;
	byte_t rx_data;
	logic  rx_err;

	// Core pins bundled as port A request
	assign core_req = '{addr: core_addr_i, wdata: core_wdata_i, we: core_we_i};

	// Shared memory, port A core, port B controller
	datamem_dp #(
		.MEM_WORDS(MEM_WORDS)
	) u_datamem_dp (
		.clk_i    (clk_i),
		.a_req_i  (core_req),
		.a_rdata_o(core_rdata_o),
		.b_req_i  (fsm_req),
		.b_rdata_o(fsm_rdata)
	);

	mcont_fsm #(
		.MEM_WORDS(MEM_WORDS)
	) u_mcont_fsm (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.mem_req_o  (fsm_req),
		.mem_rdata_i(fsm_rdata),
		.tx_start_o (tx_start),
		.tx_data_o  (tx_data),
		.tx_busy_i  (tx_busy),
		.rx_valid_i (rx_valid),
		.rx_data_i  (rx_data),
		.rx_err_i   (rx_err)
	);

	uart_tx_shift #(
		.BAUD_DIV(BAUD_DIV)
	) u_uart_tx_shift (
		.clk_i   (clk_i),
		.arst_n_i(arst_n_i),
		.start_i (tx_start),
		.data_i  (tx_data),
		.busy_o  (tx_busy),
		.txd_o   (uart_txd_o)
	);

	uart_rx_shift #(
		.BAUD_DIV(BAUD_DIV)
	) u_uart_rx_shift (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.rxd_i      (uart_rxd_i),
		.valid_o    (rx_valid),
		.data_o     (rx_data),
		.frame_err_o(rx_err)
	);

endmodule

`default_nettype wire

/* tb_proto_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_proto_top
	import mcont_pkg::*;
();

	localparam int BAUD_DIV  = 16;
	localparam int MEM_WORDS = 256;
	// One 8N1 frame in clocks
	localparam int FRAME_CYC = 10 * BAUD_DIV;
	// Bytes over all jobs, 6 tx, 9 rx, 2 rx, 0 tx
	localparam int JOB_BYTES = 17;
	localparam int TIMEOUT_CYC = (3 * JOB_BYTES * FRAME_CYC) / 2 + 2000;

	logic              clk_i;
	logic              arst_n_i;
	logic [ADDR_W-1:0] core_addr_i;
	logic [DATA_W-1:0] core_wdata_i;
	logic [3:0]        core_we_i;
	logic [DATA_W-1:0] core_rdata_o;
	logic              uart_rxd_i;
	logic              uart_txd_o;

	int          errors = 0;
	int          cycles = 0;
	logic [15:0] lfsr_q = 16'd82;
	// Serial line watch for the empty job
	logic        watch_line = 1'b0;
	int          line_low_cnt = 0;

	proto_top #(
		.BAUD_DIV (BAUD_DIV),
		.MEM_WORDS(MEM_WORDS)
	) u_proto_top (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.core_addr_i (core_addr_i),
		.core_wdata_i(core_wdata_i),
		.core_we_i   (core_we_i),
		.core_rdata_o(core_rdata_o),
		.uart_rxd_i  (uart_rxd_i),
		.uart_txd_o  (uart_txd_o)
	);

	// 100 ns period
	always #50 clk_i = ~clk_i;

	// Run limit from the total frame time
	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles with %0d errors", cycles, errors);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Count low samples while watching
	always @(negedge clk_i) begin
		if (!watch_line) begin
			line_low_cnt = 0;
		end else if (uart_txd_o !== 1'b1) begin
			line_low_cnt = line_low_cnt + 1;
		end
	end

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input mbox_u exp, input mbox_u act);
		if (act !== exp) begin
			$display("mismatch mailbox expected %h actual %h", exp, act);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic random_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			b[i]   = lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// Lanes with enable take the new byte
	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [3:0] we);
		logic [DATA_W-1:0] w;
		w = old_w;
		for (int l = 0; l < 4; l++) begin
			if (we[l]) begin
				w[l*8 +: 8] = new_w[l*8 +: 8];
			end
		end
		return w;
	endfunction

	function automatic mbox_u command_word(input logic [1:0] op, input byte_t len,
		input logic [ADDR_W-1:0] base);
		mbox_u m;
		m          = '0;
		m.cmd.go   = 1'b1;
		m.cmd.op   = op;
		m.cmd.len  = len;
		m.cmd.base = base;
		return m;
	endfunction

	// Final status, busy clear and done set
	function automatic mbox_u expected_status(input logic err, input byte_t count);
		mbox_u m;
		m            = '0;
		m.stat.done  = 1'b1;
		m.stat.err   = err;
		m.stat.count = count;
		return m;
	endfunction

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [3:0] we);
		@(negedge clk_i);
		core_addr_i  = addr;
		core_wdata_i = data;
		core_we_i    = we;
		@(negedge clk_i);
		core_we_i = 4'h0;
	endtask

	// Read data registered, valid one cycle later
	task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		@(negedge clk_i);
		core_addr_i = addr;
		core_we_i   = 4'h0;
		@(negedge clk_i);
		data = core_rdata_o;
	endtask

	task automatic poll_done(output mbox_u st);
		logic [DATA_W-1:0] w;
		logic              done_seen;
		int                polls;
		done_seen = 1'b0;
		polls     = 0;
		st        = '0;
		while (!done_seen && polls < TIMEOUT_CYC) begin
			read_word(MBOX_ADDR, w);
			st = w;
			// Command view reads busy through go
			done_seen = st.stat.done && !st.stat.busy;
			polls++;
		end
		if (!done_seen) begin
			$display("mailbox never reported done after %0d polls", polls);
			errors++;
		end
	endtask

	// Line model, samples near each bit center
	task automatic decode_tx_byte(output byte_t b);
		@(negedge uart_txd_o);
		repeat (BAUD_DIV / 2) @(negedge clk_i);
		check_bit("uart_txd_o start bit", 1'b0, uart_txd_o);
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_DIV) @(negedge clk_i);
			b[i] = uart_txd_o;
		end
		repeat (BAUD_DIV) @(negedge clk_i);
		check_bit("uart_txd_o stop bit", 1'b1, uart_txd_o);
	endtask

	// 8N1 frame plus one idle bit
	task automatic drive_rx_byte(input byte_t b, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, b, 1'b0};
		@(negedge clk_i);
		for (int i = 0; i < 10; i++) begin
			uart_rxd_i = frame[i];
			repeat (BAUD_DIV) @(negedge clk_i);
		end
		uart_rxd_i = 1'b1;
		repeat (BAUD_DIV) @(negedge clk_i);
	endtask

	task automatic reset_state();
		logic [DATA_W-1:0] rd;
		check_bit("uart_txd_o", 1'b1, uart_txd_o);
		write_word(ADDR_W'(5), 32'h5A5A_0005, 4'hF);
		read_word(ADDR_W'(5), rd);
		check_word("word 5", 32'h5A5A_0005, rd);
	endtask

	task automatic byte_lanes();
		logic [DATA_W-1:0] rd;
		write_word(ADDR_W'(6), 32'hA1B2_C3D4, 4'hF);
		write_word(ADDR_W'(6), 32'h1122_3344, 4'b0101);
		read_word(ADDR_W'(6), rd);
		check_word("word 6", merge_lanes(32'hA1B2_C3D4, 32'h1122_3344, 4'b0101), rd);
	endtask

	task automatic send_block();
		logic [DATA_W-1:0] words [2];
		byte_t             got;
		mbox_u             st;
		words[0] = 32'h4433_2211;
		words[1] = 32'h8877_6655;
		write_word(ADDR_W'(16), words[0], 4'hF);
		write_word(ADDR_W'(17), words[1], 4'hF);
		write_word(MBOX_ADDR, command_word(OP_TX, 8'd6, ADDR_W'(16)), 4'hF);
		for (int n = 0; n < 6; n++) begin
			decode_tx_byte(got);
			// LSB first out of each word
			check_byte($sformatf("tx byte %0d", n), words[n / 4][(n % 4) * 8 +: 8], got);
		end
		poll_done(st);
		check_status(expected_status(1'b0, 8'd6), st);
	endtask

	task automatic receive_block();
		byte_t             bytes [9];
		logic [DATA_W-1:0] rd;
		mbox_u             st;
		for (int w = 32; w < 35; w++) begin
			write_word(ADDR_W'(w), 32'hFFFF_FFFF, 4'hF);
		end
		write_word(MBOX_ADDR, command_word(OP_RX, 8'd9, ADDR_W'(32)), 4'hF);
		for (int n = 0; n < 9; n++) begin
			random_byte(bytes[n]);
			drive_rx_byte(bytes[n], 1'b0);
		end
		poll_done(st);
		check_status(expected_status(1'b0, 8'd9), st);
		read_word(ADDR_W'(32), rd);
		check_word("word 32", {bytes[3], bytes[2], bytes[1], bytes[0]}, rd);
		read_word(ADDR_W'(33), rd);
		check_word("word 33", {bytes[7], bytes[6], bytes[5], bytes[4]}, rd);
		// Upper lanes keep the preset
		read_word(ADDR_W'(34), rd);
		check_word("word 34", {24'hFF_FFFF, bytes[8]}, rd);
	endtask

	task automatic bad_stop_bit();
		byte_t b;
		mbox_u st;
		write_word(MBOX_ADDR, command_word(OP_RX, 8'd2, ADDR_W'(40)), 4'hF);
		random_byte(b);
		drive_rx_byte(b, 1'b0);
		random_byte(b);
		drive_rx_byte(b, 1'b1);
		poll_done(st);
		check_status(expected_status(1'b1, 8'd2), st);
	endtask

	task automatic empty_job();
		mbox_u st;
		watch_line = 1'b1;
		write_word(MBOX_ADDR, command_word(OP_TX, 8'd0, ADDR_W'(16)), 4'hF);
		poll_done(st);
		if (line_low_cnt != 0) begin
			$display("serial line went low during the zero length job");
			errors++;
		end
		watch_line = 1'b0;
		check_status(expected_status(1'b0, 8'd0), st);
	endtask

	initial begin
		clk_i        = 1'b0;
		arst_n_i     = 1'b0;
		core_addr_i  = '0;
		core_wdata_i = '0;
		core_we_i    = 4'h0;
		uart_rxd_i   = 1'b1;
		repeat (3) @(negedge clk_i);
		arst_n_i = 1'b1;
		reset_state();
		byte_lanes();
		send_block();
		receive_block();
		bad_stop_bit();
		empty_job();
		$display("errors %0d after %0d cycles", errors, cycles);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uart_rx_shift.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx_shift
	import mcont_pkg::*;
#(
	parameter int BAUD_DIV = 16
) (
	input  wire logic clk_i,
	input  wire logic arst_n_i,
	input  wire logic rxd_i,
	output logic      valid_o,
	output byte_t     data_o,
	output logic      frame_err_o
);

	// Two flop synchronizer plus edge history
	logic       rx_meta_q;
	logic       rx_sync_q;
	logic       rx_last_q;
	logic       fall;

	logic       active_q;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx_q;
	logic       valid_q;
	logic       err_q;
	byte_t      shreg_q;
	logic       restart;
	logic       tick;

	assign fall    = rx_last_q && !rx_sync_q;
	assign restart = !active_q && fall;

	baud_timer #(
		.BAUD_DIV(BAUD_DIV)
	) u_baud_timer (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.restart_i(restart),
		.half_i   (1'b1),
		.enable_i (active_q),
		.tick_o   (tick)
	);

	// Line idles high
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
			rx_last_q <= 1'b1;
		end else begin
			rx_meta_q <= rxd_i;
			rx_sync_q <= rx_meta_q;
			rx_last_q <= rx_sync_q;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			active_q  <= 1'b0;
			bit_idx_q <= '0;
			valid_q   <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (restart) begin
				active_q  <= 1'b1;
				bit_idx_q <= '0;
			end else if (active_q && tick) begin
				if (bit_idx_q == 4'd0 && rx_sync_q) begin
					// High at start center, treat as a glitch
					active_q <= 1'b0;
				end else if (bit_idx_q == 4'd9) begin
					// Stop center, a low here is a framing error
					valid_q  <= 1'b1;
					err_q    <= !rx_sync_q;
					active_q <= 1'b0;
				end else begin
					bit_idx_q <= bit_idx_q + 1'b1;
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk_i) begin
		if (active_q && tick && bit_idx_q != 4'd0 && bit_idx_q != 4'd9) begin
			shreg_q <= {rx_sync_q, shreg_q[7:1]};
		end
	end

	assign valid_o     = valid_q;
	assign data_o      = shreg_q;
	assign frame_err_o = err_q;

endmodule

`default_nettype wire

/* uart_tx_shift.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx_shift
	import mcont_pkg::*;
#(
	parameter int BAUD_DIV = 16
) (
	input  wire logic  clk_i,
	input  wire logic  arst_n_i,
	input  wire logic  start_i,
	input  wire byte_t data_i,
	output logic       busy_o,
	output logic       txd_o
);

	logic       busy_q;
	logic       txd_q;
	// Data bits then stop bit, shifted out LSB first
	logic [8:0] shreg_q;
	// Bits still to put on the line after the current one
	logic [3:0] left_q;
	logic       load;
	logic       tick;

	// Accept a byte only while idle
	assign load = start_i && !busy_q;

	baud_timer #(
		.BAUD_DIV(BAUD_DIV)
	) u_baud_timer (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.restart_i(load),
		.half_i   (1'b0),
		.enable_i (busy_q),
		.tick_o   (tick)
	);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			txd_q  <= 1'b1;
			left_q <= '0;
		end else if (load) begin
			// Start bit goes out right away
			busy_q <= 1'b1;
			txd_q  <= 1'b0;
			left_q <= 4'd9;
		end else if (busy_q && tick) begin
			if (left_q != '0) begin
				txd_q  <= shreg_q[0];
				left_q <= left_q - 1'b1;
			end else begin
				// Stop bit period over, line already high
				busy_q <= 1'b0;
			end
		end
	end

	// Frame payload
	always_ff @(posedge clk_i) begin
		if (load) begin
			shreg_q <= {1'b1, data_i};
		end else if (busy_q && tick) begin
			shreg_q <= {1'b1, shreg_q[8:1]};
		end
	end

	assign busy_o = busy_q;
	assign txd_o  = txd_q;

endmodule

`default_nettype wire

/* verilog.f */
mcont_pkg.sv
datamem_dp.sv
baud_timer.sv
uart_tx_shift.sv
uart_rx_shift.sv
mcont_fsm.sv
proto_top.sv
tb_proto_top.sv
